/* dino_runner.f */
+incdir+include
logic/sprite_pkg.sv
logic/game_ctrl_pkg.sv
logic/dinosaur.sv
logic/cactus_scroller.sv
logic/collision_score.sv
logic/dino_runner_top.sv
verif/tb_clock_gen.sv
verif/dino_runner_asserts.sv
verif/dino_runner_tb.sv

/* include/dino_runner_params.svh */
/*
 * screen, floor and sprite geometry of the runner game
 * jump physics and obstacle speed constants
 */
`ifndef DINO_RUNNER_PARAMS_SVH
`define DINO_RUNNER_PARAMS_SVH

// playfield
`define SCREEN_WIDTH        640     // right edge, cactus respawn reference
`define FLOOR_HEIGHT        400     // y of the ground line, grows downward

// player sprite, sizes are half extents around the centre
`define DINO_X              80      // fixed horizontal centre
`define DINO_WIDTH          16      // half width
`define DINO_HEIGHT         20      // half height standing
`define DINO_DUCK_HEIGHT    10      // half height ducking

// jump physics, per animation frame
`define DINO_JUMP_STRENGTH  16      // initial upward speed
`define DINO_GRAVITY        1       // speed gained each frame

// obstacle
`define CACTUS_WIDTH        8       // half width
`define CACTUS_HEIGHT       16      // half height
`define CACTUS_SPEED        4       // pixels left per frame

// coordinate bus width, 0..4095
`define COORD_BITS          12

`endif

/* logic/cactus_scroller.sv */
/*
 * obstacle sprite scrolling left with respawn at the right edge
 */
`include "dino_runner_params.svh"

module cactus_scroller (
    input  logic             i_clk,
    input  logic             i_rst,                // sync, active high
    input  logic             i_restart,            // pulse from game FSM
    input  logic             i_step,               // one frame advance
    output sprite_pkg::box_t o_box                 // current edges
);

    localparam int CW = `COORD_BITS;

    typedef logic        [CW-1:0] coord_t;         // screen coordinate
    typedef logic signed [CW:0]   scoord_t;        // may go left of zero

    localparam scoord_t START_X = scoord_t'(`SCREEN_WIDTH);                 // reset centre
    localparam scoord_t WRAP_X  = scoord_t'(`SCREEN_WIDTH + `CACTUS_WIDTH); // respawn centre
    localparam scoord_t HALF_W  = scoord_t'(`CACTUS_WIDTH);
    localparam scoord_t SPEED   = scoord_t'(`CACTUS_SPEED);

    scoord_t x;                                    // centre x
    scoord_t x_next;                               // centre after this frame
    scoord_t right_next;                           // right edge after this frame
    logic    wrap;                                 // fully off the left side

    assign x_next     = x - SPEED;
    assign right_next = x_next + HALF_W;
    assign wrap       = right_next[CW];            // sign bit, edge below zero

    always_ff @(posedge i_clk) begin
        if (i_rst || i_restart) begin
            x <= START_X;                          // sits at right edge
        end else if (i_step) begin
            x <= wrap ? WRAP_X : x_next;           // fixed respawn spot
        end
    end

    // edges truncate to the coordinate width; off-screen values are harmless
    assign o_box.x1 = coord_t'(x - HALF_W);
    assign o_box.x2 = coord_t'(x + HALF_W);
    assign o_box.y1 = coord_t'(`FLOOR_HEIGHT - 2 * `CACTUS_HEIGHT); // top
    assign o_box.y2 = coord_t'(`FLOOR_HEIGHT);     // stands on floor

endmodule

/* logic/collision_score.sv */
/*
 * bounding box overlap test
 * run/over FSM, restart pulse and frame score
 */
module collision_score (
    input  logic                   i_clk,
    input  logic                   i_rst,          // sync, active high
    input  logic                   i_ani_stb,      // one cycle per frame
    input  logic                   i_animate,      // level, pauses game
    input  logic                   i_jump,         // restarts when over
    input  sprite_pkg::box_t       i_dino,         // player edges
    input  sprite_pkg::box_t       i_cactus,       // obstacle edges
    output logic                   o_frame_en,     // sprites may move
    output logic                   o_restart,      // one cycle, to sprites
    output game_ctrl_pkg::status_t o_status        // over flag and score
);

    game_ctrl_pkg::game_state_t state;             // run / over
    logic [15:0]                score;             // frames survived
    logic                       strobe;            // frame accepted
    logic                       hit;               // boxes overlap

    assign strobe = i_ani_stb && i_animate;        // paused frames do nothing

    // strict compares, touching edges do not count
    assign hit = (i_dino.x1   < i_cactus.x2) &&
                 (i_cactus.x1 < i_dino.x2)   &&
                 (i_dino.y1   < i_cactus.y2) &&
                 (i_cactus.y1 < i_dino.y2);

    assign o_frame_en = (state == game_ctrl_pkg::GAME_RUN);
    assign o_restart  = (state == game_ctrl_pkg::GAME_OVER) && strobe && i_jump;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            state <= game_ctrl_pkg::GAME_RUN;
            score <= '0;
        end else begin
            case (state)
                game_ctrl_pkg::GAME_RUN: begin
                    if (strobe) begin
                        if (hit) begin
                            state <= game_ctrl_pkg::GAME_OVER; // score freezes here
                        end else begin
                            score <= score + 16'd1;
                        end
                    end
                end
                game_ctrl_pkg::GAME_OVER: begin
                    if (o_restart) begin   // sprites reload on same edge
                        state <= game_ctrl_pkg::GAME_RUN;
                        score <= '0;
                    end
                end
                default: begin
                    state <= game_ctrl_pkg::GAME_RUN;
                end
            endcase
        end
    end

    assign o_status.game_over = (state == game_ctrl_pkg::GAME_OVER);
    assign o_status.score     = score;

endmodule

/* logic/dino_runner_top.sv */
/*
 * runner game core, player, obstacle and collision/score blocks
 */
module dino_runner_top (
    input  logic                    i_clk,
    input  logic                    i_rst,         // sync, active high
    input  logic                    i_ani_stb,     // frame pulse
    input  logic                    i_animate,     // pause when low
    input  game_ctrl_pkg::buttons_t i_buttons,     // raw jump / duck
    output sprite_pkg::box_t        o_dino_box,
    output sprite_pkg::box_t        o_cactus_box,
    output game_ctrl_pkg::status_t  o_status
);

    logic             frame_en;                    // high while running
    logic             restart;                     // reload both sprites
    logic             step;                        // enabled frame
    sprite_pkg::box_t dino_box;
    sprite_pkg::box_t cactus_box;

    assign step = i_ani_stb && i_animate && frame_en; // sprites never see game state

    dinosaur dino0 (
        .i_clk     (i_clk),
        .i_rst     (i_rst),
        .i_restart (restart),
        .i_step    (step),
        .i_buttons (i_buttons),
        .o_box     (dino_box)
    );

    cactus_scroller cactus0 (
        .i_clk     (i_clk),
        .i_rst     (i_rst),
        .i_restart (restart),
        .i_step    (step),
        .o_box     (cactus_box)
    );

    collision_score coll0 (
        .i_clk      (i_clk),
        .i_rst      (i_rst),
        .i_ani_stb  (i_ani_stb),
        .i_animate  (i_animate),
        .i_jump     (i_buttons.jump),
        .i_dino     (dino_box),
        .i_cactus   (cactus_box),
        .o_frame_en (frame_en),
        .o_restart  (restart),
        .o_status   (o_status)
    );

    assign o_dino_box   = dino_box;
    assign o_cactus_box = cactus_box;

endmodule

/* logic/dinosaur.sv */
/*
 * player sprite with jump, gravity and duck model
 */
`include "dino_runner_params.svh"

module dinosaur (
    input  logic                    i_clk,
    input  logic                    i_rst,         // sync, active high
    input  logic                    i_restart,     // pulse from game FSM
    input  logic                    i_step,        // one frame advance
    input  game_ctrl_pkg::buttons_t i_buttons,     // jump / duck levels
    output sprite_pkg::box_t        o_box          // current edges
);

    localparam int CW = `COORD_BITS;

    typedef logic        [CW-1:0] coord_t;         // screen coordinate
    typedef logic signed [CW:0]   scoord_t;        // extra bit for signed math

    localparam scoord_t RUN_Y  = scoord_t'(`FLOOR_HEIGHT - `DINO_HEIGHT);      // standing centre
    localparam scoord_t DUCK_Y = scoord_t'(`FLOOR_HEIGHT - `DINO_DUCK_HEIGHT); // ducked centre
    localparam scoord_t JUMP_V = scoord_t'(`DINO_JUMP_STRENGTH);
    localparam scoord_t GRAV   = scoord_t'(`DINO_GRAVITY);
    localparam scoord_t FULL_H = scoord_t'(`DINO_HEIGHT);
    localparam scoord_t DUCK_H = scoord_t'(`DINO_DUCK_HEIGHT);

    sprite_pkg::dino_state_t state;                // motion state
    scoord_t                 y;                    // centre y
    scoord_t                 y_vel;                // negative is upward
    scoord_t                 y_fall;               // candidate centre in flight
    scoord_t                 half_h;               // half height for this state
    logic                    landing;              // next flight step reaches floor

    assign y_fall  = y + y_vel;                    // move by current speed
    assign landing = (y_fall >= RUN_Y);            // would sink into floor
    assign half_h  = (state == sprite_pkg::DINO_DUCK) ? DUCK_H : FULL_H;

    always_ff @(posedge i_clk) begin
        if (i_rst || i_restart) begin
            state <= sprite_pkg::DINO_RUN;         // back on the floor
            y     <= RUN_Y;
            y_vel <= '0;
        end else if (i_step) begin
            case (state)
                sprite_pkg::DINO_RUN: begin
                    if (i_buttons.jump) begin      // jump wins over duck
                        state <= sprite_pkg::DINO_JUMP;
                        y_vel <= -JUMP_V;
                        y     <= RUN_Y - JUMP_V;   // first rise right away
                    end else if (i_buttons.duck) begin
                        state <= sprite_pkg::DINO_DUCK;
                        y     <= DUCK_Y;           // keep bottom on floor
                    end
                end
                sprite_pkg::DINO_JUMP: begin       // buttons ignored mid-air
                    if (landing) begin
                        state <= sprite_pkg::DINO_RUN;
                        y     <= RUN_Y;            // clamp to floor
                        y_vel <= '0;
                    end else begin
                        y     <= y_fall;
                        y_vel <= y_vel + GRAV;     // gravity pulls down
                    end
                end
                sprite_pkg::DINO_DUCK: begin
                    if (!i_buttons.duck) begin     // stand back up
                        state <= sprite_pkg::DINO_RUN;
                        y     <= RUN_Y;
                    end
                end
                default: begin
                    state <= sprite_pkg::DINO_RUN; // illegal code recovery
                    y     <= RUN_Y;
                    y_vel <= '0;
                end
            endcase
        end
    end

    // horizontal position is fixed, vertical follows the centre
    assign o_box.x1 = coord_t'(`DINO_X - `DINO_WIDTH);
    assign o_box.x2 = coord_t'(`DINO_X + `DINO_WIDTH);
    assign o_box.y1 = coord_t'(y - half_h);        // top
    assign o_box.y2 = coord_t'(y + half_h);        // bottom

endmodule

/* logic/game_ctrl_pkg.sv */
/*
 * player button struct
 * game state enum and status struct
 */
package game_ctrl_pkg;

    // raw button levels
    typedef struct packed {
        logic jump;                    // jump / restart
        logic duck;                    // crouch while on floor
    } buttons_t;

    // overall game FSM
    typedef enum logic {
        GAME_RUN  = 1'b0,              // frames advance, score counts
        GAME_OVER = 1'b1               // frozen until jump
    } game_state_t;

    // what the outside world sees
    typedef struct packed {
        logic        game_over;        // collision happened
        logic [15:0] score;            // frames survived
    } status_t;

endpackage

/* logic/sprite_pkg.sv */
/*
 * sprite bounding box struct
 * dinosaur motion states
 */
`include "dino_runner_params.svh"

package sprite_pkg;

    // edges of one sprite in screen pixels
    typedef struct packed {
        logic [`COORD_BITS-1:0] x1;    // left
        logic [`COORD_BITS-1:0] x2;    // right
        logic [`COORD_BITS-1:0] y1;    // top
        logic [`COORD_BITS-1:0] y2;    // bottom
    } box_t;

    // player motion
    typedef enum logic [1:0] {
        DINO_RUN  = 2'd0,              // on floor, full height
        DINO_JUMP = 2'd1,              // airborne, ballistic
        DINO_DUCK = 2'd2               // on floor, short height
    } dino_state_t;

endpackage

/* verif/dino_runner_asserts.sv */
/*
 * concurrent checks on the game core, bound to the top level
 */
`include "dino_runner_params.svh"

module dino_runner_asserts (
    input logic                   i_clk,
    input logic                   i_rst,
    input logic                   i_restart,      // internal restart pulse
    input sprite_pkg::box_t       i_dino_box,
    input game_ctrl_pkg::status_t i_status
);
    timeunit 1ns;
    timeprecision 100ps;

    // player never sinks below the ground line
    floor_a: assert property (@(posedge i_clk) disable iff (i_rst)
        i_dino_box.y2 <= `FLOOR_HEIGHT)
        else $error("dinosaur bottom edge below the floor");

    // only a restart clears the over flag
    over_hold_a: assert property (@(posedge i_clk) disable iff (i_rst)
        $fell(i_status.game_over) |-> $past(i_restart))
        else $error("game over flag dropped without a restart");

    // frozen score while over
    score_freeze_a: assert property (@(posedge i_clk) disable iff (i_rst)
        (i_status.game_over && !i_restart) |=> $stable(i_status.score))
        else $error("score changed while the game is over");

endmodule

bind dino_runner_top dino_runner_asserts asrt0 (
    .i_clk      (i_clk),
    .i_rst      (i_rst),
    .i_restart  (restart),
    .i_dino_box (o_dino_box),
    .i_status   (o_status)
);

/* verif/dino_runner_patterns.mem */
// cnt anim jump duck | dino_y1 dino_y2 cactus_x1 score game_over (all hex)
// cnt strobes are sent with these inputs, then the outputs are checked
01 0 0 0 168 190 278 0000 0
01 1 0 0 168 190 274 0001 0
01 1 1 0 158 180 270 0002 0
01 1 1 0 148 170 26C 0003 0
01 1 0 0 139 161 268 0004 0
0E 1 0 0 0D0 0F8 230 0012 0
11 1 0 0 158 180 1EC 0023 0
01 1 0 0 168 190 1E8 0024 0
01 1 0 1 17C 190 1E4 0025 0
03 1 0 1 17C 190 1D8 0028 0
01 0 0 1 17C 190 1D8 0028 0
01 1 0 0 168 190 1D4 0029 0
02 0 1 0 168 190 1D4 0029 0
01 1 0 0 168 190 1D0 002A 0
5D 1 0 0 168 190 05C 0087 0
01 1 0 0 168 190 058 0087 1
04 1 0 0 168 190 058 0087 1
01 1 0 1 168 190 058 0087 1
01 0 1 0 168 190 058 0087 1
01 1 1 0 168 190 278 0000 0
01 1 0 0 168 190 274 0001 0
81 1 0 0 168 190 070 0082 0
01 1 1 0 158 180 06C 0083 0
1F 1 0 0 139 161 FF0 00A2 0
01 1 0 0 148 170 280 00A3 0
01 1 0 0 158 180 27C 00A4 0
01 1 0 0 168 190 278 00A5 0

/* verif/dino_runner_tb.sv */
/*
 * testbench for the runner core, driven from the pattern file
 * clock source, DUT, frame driver, output checker and timeout
 */
`include "dino_runner_params.svh"

module dino_runner_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int FIELDS   = 9;                   // words per pattern record
    localparam int MAX_RECS = 64;                  // pattern memory capacity

    typedef logic [`COORD_BITS-1:0] coord_t;       // screen coordinate

    // edges fixed by the screen geometry
    localparam coord_t DINO_LEFT   = coord_t'(`DINO_X - `DINO_WIDTH);
    localparam coord_t DINO_RIGHT  = coord_t'(`DINO_X + `DINO_WIDTH);
    localparam coord_t CACTUS_TOP  = coord_t'(`FLOOR_HEIGHT - 2 * `CACTUS_HEIGHT);
    localparam coord_t CACTUS_BOT  = coord_t'(`FLOOR_HEIGHT);   // rests on floor
    localparam coord_t CACTUS_SPAN = coord_t'(2 * `CACTUS_WIDTH); // left to right edge

    logic                    clk;
    logic                    rst;
    logic                    ani_stb;              // frame pulse to DUT
    logic                    animate;              // pause level
    game_ctrl_pkg::buttons_t buttons;
    sprite_pkg::box_t        dino_box;
    sprite_pkg::box_t        cactus_box;
    game_ctrl_pkg::status_t  status;

    logic [15:0] pat [0:FIELDS*MAX_RECS-1];        // flat record memory
    int          num_recs;
    int          total_strobes;                    // sum of record counts
    int          cycle_limit;                      // 0 until file is parsed
    int          cycle_count;
    int          error_count;

    tb_clock_gen clk0 (
        .o_clk (clk),
        .o_rst (rst)
    );

    dino_runner_top dut0 (
        .i_clk        (clk),
        .i_rst        (rst),
        .i_ani_stb    (ani_stb),
        .i_animate    (animate),
        .i_buttons    (buttons),
        .o_dino_box   (dino_box),
        .o_cactus_box (cactus_box),
        .o_status     (status)
    );

    // compare one output field with its pattern value
    task automatic check_value(input string what, input logic [15:0] got,
                               input logic [15:0] exp);
        if (got !== exp) begin
            error_count++;
            $display("error at %0t ns: %s got 0x%0h expected 0x%0h", $time, what, got, exp);
            $display("=== FAIL ===");
            $fatal(1, "output mismatch");
        end
    endtask

    // random gap, then a single strobe with the record's inputs
    task automatic send_frame(input logic anim, input logic jmp, input logic dk);
        int idle;
        idle = $urandom % 4;                       // 0 to 3 quiet cycles
        repeat (idle) @(posedge clk);
        @(posedge clk);
        ani_stb      <= 1'b1;
        animate      <= anim;
        buttons.jump <= jmp;
        buttons.duck <= dk;
        @(posedge clk);                            // DUT takes the frame here
        ani_stb <= 1'b0;
        @(negedge clk);                            // outputs settled
    endtask

    task automatic check_record(input int r);
        int     base;
        coord_t cactus_right;
        base         = r * FIELDS;
        cactus_right = coord_t'(pat[base+6]) + CACTUS_SPAN; // wraps like the screen bus
        check_value($sformatf("record %0d dino x1", r), dino_box.x1, DINO_LEFT);
        check_value($sformatf("record %0d dino x2", r), dino_box.x2, DINO_RIGHT);
        check_value($sformatf("record %0d dino y1", r), dino_box.y1, pat[base+4]);
        check_value($sformatf("record %0d dino y2", r), dino_box.y2, pat[base+5]);
        check_value($sformatf("record %0d cactus x1", r), cactus_box.x1, pat[base+6]);
        check_value($sformatf("record %0d cactus x2", r), cactus_box.x2, cactus_right);
        check_value($sformatf("record %0d cactus y1", r), cactus_box.y1, CACTUS_TOP);
        check_value($sformatf("record %0d cactus y2", r), cactus_box.y2, CACTUS_BOT);
        check_value($sformatf("record %0d score", r), status.score, pat[base+7]);
        check_value($sformatf("record %0d game over", r), status.game_over, pat[base+8]);
    endtask

    // hung run guard
    initial begin
        cycle_count = 0;
        wait (cycle_limit > 0);
        while (cycle_count < cycle_limit) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout: run exceeded %0d clock cycles", cycle_limit);
        $display("=== FAIL ===");
        $fatal(1, "simulation timeout");
    end

    initial begin
        int          r;
        int          n;
        int unsigned seed_dummy;
        ani_stb       = 1'b0;
        animate       = 1'b0;
        buttons       = '0;
        error_count   = 0;
        num_recs      = 0;
        total_strobes = 0;
        cycle_limit   = 0;
        seed_dummy    = $urandom(64);               // fixed seed for idle gaps
        $readmemh("verif/dino_runner_patterns.mem", pat);
        // records end at a zero or missing count word
        while (num_recs < MAX_RECS && !$isunknown(pat[num_recs*FIELDS]) &&
               pat[num_recs*FIELDS] != 16'd0) begin
            total_strobes += pat[num_recs*FIELDS];
            num_recs++;
        end
        if (num_recs == 0) begin
            $display("no pattern records found in the stimulus file");
            $display("=== FAIL ===");
            $fatal(1, "empty pattern file");
        end
        cycle_limit = total_strobes * 6 + 50;      // worst gap plus reset margin
        wait (rst === 1'b1);
        wait (rst === 1'b0);
        @(negedge clk);
        for (r = 0; r < num_recs; r++) begin
            for (n = 0; n < pat[r*FIELDS]; n++) begin
                send_frame(pat[r*FIELDS+1][0], pat[r*FIELDS+2][0], pat[r*FIELDS+3][0]);
            end
            check_record(r);
        end
        if (error_count == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

/* verif/tb_clock_gen.sv */
/*
 * testbench clock and synchronous reset source
 */
module tb_clock_gen (
    output logic o_clk,
    output logic o_rst
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam int RST_CYCLES = 5;                 // reset length in clocks

    initial begin
        o_clk = 1'b0;
        forever #20 o_clk = ~o_clk;                // 40 ns period
    end

    initial begin
        o_rst = 1'b1;
        repeat (RST_CYCLES) @(posedge o_clk);
        o_rst <= 1'b0;                             // released on an edge
    end

endmodule
